// ==== src/tomasulo_pkg.sv ====
// tomasulo core shared definitions
// widths, opcodes, unit latencies, station depth and the common data bus type
package tomasulo_pkg;

  // datapath and register file sizes
  localparam int data_w   = 32;
  localparam int reg_w    = 3;
  localparam int num_regs = 8;
  localparam int op_w     = 3;
  localparam int instr_w  = 12;

  typedef logic [data_w-1:0] data_t;
  typedef logic [reg_w-1:0]  reg_idx_t;
  typedef logic [op_w-1:0]   opcode_t;

  // instruction layout is op, dest, src a, src b
  localparam opcode_t op_nop = 3'd0;
  localparam opcode_t op_ld  = 3'd1;
  localparam opcode_t op_st  = 3'd2;
  localparam opcode_t op_add = 3'd3;
  localparam opcode_t op_mul = 3'd4;

  // entries per reservation station
  localparam int rs_depth = 4;

  // fixed unit latencies in cycles, dispatch edge to result valid
  localparam int add_latency = 2;
  localparam int mul_latency = 4;

  typedef enum logic {
    fu_add,
    fu_mul
  } fu_kind_t;

  // one broadcast on the common data bus
  typedef struct packed {
    logic     valid;
    reg_idx_t dest;
    data_t    data;
  } cdb_t;

endpackage

// ==== src/tomasulo_ifs.sv ====
// tomasulo core internal interfaces
// issue port into a station, station to unit dispatch, unit result to the arbiter
`timescale 1ns/10ps

interface issue_if;
  import tomasulo_pkg::*;

  // one entry per cycle while valid is high
  logic     valid;
  reg_idx_t dest;
  // operand value when ready, otherwise the producing register as tag
  logic     a_ready;
  reg_idx_t a_tag;
  data_t    a_val;
  logic     b_ready;
  reg_idx_t b_tag;
  data_t    b_val;
  // no free slot
  logic     full;

  modport issuer (output valid, dest, a_ready, a_tag, a_val, b_ready, b_tag, b_val,
                  input full);
  modport station (input valid, dest, a_ready, a_tag, a_val, b_ready, b_tag, b_val,
                   output full);
endinterface

interface dispatch_if;
  import tomasulo_pkg::*;

  // transfer on valid and ready
  logic     valid;
  reg_idx_t dest;
  data_t    a;
  data_t    b;
  logic     ready;

  modport station (output valid, dest, a, b, input ready);
  modport unit (input valid, dest, a, b, output ready);
endinterface

interface result_if (input logic clk);
  import tomasulo_pkg::*;

  // held stable until grant
  logic     valid;
  reg_idx_t dest;
  data_t    data;
  logic     grant;

  modport unit (output valid, dest, data, input grant);
  modport arbiter (input clk, valid, dest, data, output grant);
endinterface

// ==== src/issue_unit.sv ====
// instruction issue logic
// four-phase req/ack port, opcode decode, WAW and full-station stall,
// routing of operands or tags to the add or multiply station
`timescale 1ns/10ps

module issue_unit (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             instr_req,
  input  logic [tomasulo_pkg::instr_w-1:0] instr,
  input  tomasulo_pkg::data_t              rd_a_val,
  input  tomasulo_pkg::data_t              rd_b_val,
  input  logic                             rd_a_busy,
  input  logic                             rd_b_busy,
  input  logic                             dest_busy,
  output logic                             instr_ack,
  output tomasulo_pkg::reg_idx_t           rd_a_addr,
  output tomasulo_pkg::reg_idx_t           rd_b_addr,
  output tomasulo_pkg::reg_idx_t           dest_addr,
  output logic                             mark_busy,
  issue_if.issuer                          add_issue,
  issue_if.issuer                          mul_issue
);
  import tomasulo_pkg::*;

  opcode_t  op;
  reg_idx_t dest;
  reg_idx_t src_a;
  reg_idx_t src_b;
  logic     is_add;
  logic     is_mul;
  logic     dest_free;
  logic     can_issue;
  logic     accept;

  // op, dest, src a, src b from msb down
  assign {op, dest, src_a, src_b} = instr;

  // register file lookups are combinational
  assign rd_a_addr = src_a;
  assign rd_b_addr = src_b;
  assign dest_addr = dest;

  always_comb begin
    is_add = (op == op_add);
    is_mul = (op == op_mul);
    // r0 is never busy, but say so explicitly
    dest_free = (dest == '0) || !dest_busy;
    if (is_add) begin
      can_issue = dest_free && !add_issue.full;
    end else if (is_mul) begin
      can_issue = dest_free && !mul_issue.full;
    end else begin
      // nop, ld, st and unknown codes are dropped on ack
      can_issue = 1'b1;
    end
  end

  // accept once per req pulse, on the edge that raises ack
  assign accept = instr_req && !instr_ack && can_issue;

  assign mark_busy = accept && (is_add || is_mul) && (dest != '0);

  // same fields to both stations, only valid selects
  assign add_issue.valid   = accept && is_add;
  assign mul_issue.valid   = accept && is_mul;
  assign add_issue.dest    = dest;
  assign mul_issue.dest    = dest;
  assign add_issue.a_ready = !rd_a_busy;
  assign mul_issue.a_ready = !rd_a_busy;
  assign add_issue.a_tag   = src_a;
  assign mul_issue.a_tag   = src_a;
  assign add_issue.a_val   = rd_a_val;
  assign mul_issue.a_val   = rd_a_val;
  assign add_issue.b_ready = !rd_b_busy;
  assign mul_issue.b_ready = !rd_b_busy;
  assign add_issue.b_tag   = src_b;
  assign mul_issue.b_tag   = src_b;
  assign add_issue.b_val   = rd_b_val;
  assign mul_issue.b_val   = rd_b_val;

  // ack holds until req is seen low
  always_ff @(posedge clk) begin
    if (rst) begin
      instr_ack <= 1'b0;
    end else if (accept) begin
      instr_ack <= 1'b1;
    end else if (instr_ack && !instr_req) begin
      instr_ack <= 1'b0;
    end
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(instr_ack) |-> $past(instr_req));

endmodule

// ==== src/register_status_file.sv ====
// register file with busy table
// eight registers, r0 fixed at zero, reset value of rN is N
// busy bit marks a register with a pending writer in flight
// issue reads bypass a same-cycle bus write; debug port reads raw state
`timescale 1ns/10ps

module register_status_file (
  input  logic                   clk,
  input  logic                   rst,
  input  tomasulo_pkg::reg_idx_t rd_a_addr,
  input  tomasulo_pkg::reg_idx_t rd_b_addr,
  input  tomasulo_pkg::reg_idx_t dest_addr,
  input  tomasulo_pkg::reg_idx_t dbg_addr,
  input  logic                   mark_busy,
  input  tomasulo_pkg::cdb_t     cdb,
  output tomasulo_pkg::data_t    rd_a_val,
  output tomasulo_pkg::data_t    rd_b_val,
  output tomasulo_pkg::data_t    dbg_data,
  output logic                   rd_a_busy,
  output logic                   rd_b_busy,
  output logic                   dest_busy,
  output logic                   dbg_busy
);
  import tomasulo_pkg::*;

  data_t               regs [num_regs];
  logic [num_regs-1:0] busy;
  logic                cdb_wr;

  // results aimed at r0 are dropped here
  assign cdb_wr = cdb.valid && (cdb.dest != '0);

  function automatic data_t read_val(input reg_idx_t addr);
    data_t val;
    if (addr == '0) begin
      val = '0;
    end else if (cdb_wr && (cdb.dest == addr)) begin
      val = cdb.data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  // a register being written this cycle already counts as ready
  function automatic logic read_busy(input reg_idx_t addr);
    return busy[addr] && !(cdb_wr && (cdb.dest == addr));
  endfunction

  always_comb begin
    rd_a_val  = read_val(rd_a_addr);
    rd_b_val  = read_val(rd_b_addr);
    rd_a_busy = read_busy(rd_a_addr);
    rd_b_busy = read_busy(rd_b_addr);
    dest_busy = read_busy(dest_addr);
  end

  assign dbg_data = regs[dbg_addr];
  assign dbg_busy = busy[dbg_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < num_regs; r++) begin
        regs[r] <= data_t'(r);
      end
      busy <= '0;
    end else begin
      if (cdb_wr) begin
        regs[cdb.dest] <= cdb.data;
        busy[cdb.dest] <= 1'b0;
      end
      // set comes last so a reissue on the clearing edge keeps the bit
      if (mark_busy && (dest_addr != '0)) begin
        busy[dest_addr] <= 1'b1;
      end
    end
  end

  // only the single pending writer of a register may broadcast to it
  wr_only_busy: assert property (@(posedge clk) disable iff (rst)
    cdb_wr |-> busy[cdb.dest]);

endmodule

// ==== src/reservation_station.sv ====
// reservation station
// rs_depth entries waiting on operands, tagged by producing register
// snoops the common data bus for missing operands and dispatches the
// lowest-indexed ready entry to its functional unit
`timescale 1ns/10ps

module reservation_station (
  input  logic               clk,
  input  logic               rst,
  input  tomasulo_pkg::cdb_t cdb,
  issue_if.station           iss,
  dispatch_if.station        disp
);
  import tomasulo_pkg::*;

  typedef logic [$clog2(rs_depth)-1:0] slot_t;

  // entry control
  logic [rs_depth-1:0] in_use;
  logic [rs_depth-1:0] a_rdy;
  logic [rs_depth-1:0] b_rdy;
  // entry payload
  reg_idx_t            dest_q [rs_depth];
  reg_idx_t            a_tag  [rs_depth];
  reg_idx_t            b_tag  [rs_depth];
  data_t               a_val  [rs_depth];
  data_t               b_val  [rs_depth];

  logic [rs_depth-1:0] a_hit;
  logic [rs_depth-1:0] b_hit;
  logic [rs_depth-1:0] ready;
  slot_t               alloc_idx;
  slot_t               disp_idx;
  logic                disp_any;
  logic                do_alloc;
  logic                do_disp;

  // bus snoop per waiting operand
  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      a_hit[i] = in_use[i] && !a_rdy[i] && cdb.valid && (cdb.dest == a_tag[i]);
      b_hit[i] = in_use[i] && !b_rdy[i] && cdb.valid && (cdb.dest == b_tag[i]);
    end
  end

  assign ready = in_use & a_rdy & b_rdy;

  // lowest free slot and lowest ready slot, scanned top down
  always_comb begin
    alloc_idx = '0;
    disp_idx  = '0;
    disp_any  = 1'b0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!in_use[i]) begin
        alloc_idx = slot_t'(i);
      end
      if (ready[i]) begin
        disp_idx = slot_t'(i);
        disp_any = 1'b1;
      end
    end
  end

  // a slot freed this cycle is not offered until the next one
  assign iss.full = &in_use;
  assign do_alloc = iss.valid && !iss.full;

  assign disp.valid = disp_any;
  assign disp.dest  = dest_q[disp_idx];
  assign disp.a     = a_val[disp_idx];
  assign disp.b     = b_val[disp_idx];
  assign do_disp    = disp.valid && disp.ready;

  // alloc and dispatch never hit the same slot
  always_ff @(posedge clk) begin
    if (rst) begin
      in_use <= '0;
      a_rdy  <= '0;
      b_rdy  <= '0;
    end else begin
      a_rdy <= a_rdy | a_hit;
      b_rdy <= b_rdy | b_hit;
      if (do_disp) begin
        in_use[disp_idx] <= 1'b0;
      end
      if (do_alloc) begin
        in_use[alloc_idx] <= 1'b1;
        a_rdy[alloc_idx]  <= iss.a_ready;
        b_rdy[alloc_idx]  <= iss.b_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (a_hit[i]) begin
        a_val[i] <= cdb.data;
      end
      if (b_hit[i]) begin
        b_val[i] <= cdb.data;
      end
    end
    if (do_alloc) begin
      dest_q[alloc_idx] <= iss.dest;
      a_tag[alloc_idx]  <= iss.a_tag;
      b_tag[alloc_idx]  <= iss.b_tag;
      a_val[alloc_idx]  <= iss.a_val;
      b_val[alloc_idx]  <= iss.b_val;
    end
  end

  // issue logic must see full before it offers an entry
  no_issue_when_full: assert property (@(posedge clk) disable iff (rst)
    iss.valid |-> !iss.full);

endmodule

// ==== src/functional_unit.sv ====
// fixed-latency functional unit
// one operation at a time, add or low 32 bits of a multiply
// result stays valid and stable until the bus arbiter grants it
`timescale 1ns/10ps

module functional_unit #(
  parameter tomasulo_pkg::fu_kind_t kind    = tomasulo_pkg::fu_add,
  parameter int                     latency = tomasulo_pkg::add_latency
) (
  input  logic     clk,
  input  logic     rst,
  dispatch_if.unit disp,
  result_if.unit   res
);
  import tomasulo_pkg::*;

  typedef logic [$clog2(latency + 1)-1:0] count_t;

  logic     running;
  logic     res_valid;
  count_t   count;
  logic     start;
  logic     finish;
  reg_idx_t dest_q;
  data_t    op_a;
  data_t    op_b;
  data_t    result;
  data_t    res_data;

  // busy while computing or while holding an ungranted result
  assign disp.ready = !running && !res_valid;
  assign start      = disp.valid && disp.ready;
  assign finish     = running && (count == '0);

  // product truncates to data_w in this context
  assign result = (kind == fu_add) ? op_a + op_b : op_a * op_b;

  assign res.valid = res_valid;
  assign res.dest  = dest_q;
  assign res.data  = res_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      running   <= 1'b0;
      res_valid <= 1'b0;
      count     <= '0;
    end else begin
      if (start) begin
        running <= 1'b1;
        count   <= count_t'(latency - 1);
      end else if (finish) begin
        running   <= 1'b0;
        res_valid <= 1'b1;
      end else if (running) begin
        count <= count - 1'b1;
      end
      if (res_valid && res.grant) begin
        res_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dest_q <= disp.dest;
      op_a   <= disp.a;
      op_b   <= disp.b;
    end
    if (finish) begin
      res_data <= result;
    end
  end

  hold_until_grant: assert property (@(posedge clk) disable iff (rst)
    res_valid && !res.grant |=> res_valid && $stable(res_data) && $stable(dest_q));

endmodule

// ==== src/cdb_arbiter.sv ====
// common data bus arbiter
// fixed priority, add unit ahead of the multiply unit
// broadcast is combinational from the granted result
`timescale 1ns/10ps

module cdb_arbiter (
  result_if.arbiter          add_res,
  result_if.arbiter          mul_res,
  output tomasulo_pkg::cdb_t cdb
);

  assign add_res.grant = add_res.valid;
  // multiply waits behind any add result
  assign mul_res.grant = mul_res.valid && !add_res.valid;

  always_comb begin
    cdb = '0;
    if (add_res.grant) begin
      cdb.valid = 1'b1;
      cdb.dest  = add_res.dest;
      cdb.data  = add_res.data;
    end else if (mul_res.grant) begin
      cdb.valid = 1'b1;
      cdb.dest  = mul_res.dest;
      cdb.data  = mul_res.data;
    end
  end

  one_grant: assert property (@(posedge add_res.clk)
    !(add_res.grant && mul_res.grant));

endmodule

// ==== src/tomasulo_core.sv ====
// tomasulo integer core top level
// issue logic and register status file feed an add and a multiply
// reservation station; the units share the common data bus through an arbiter
`timescale 1ns/10ps

module tomasulo_core (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             instr_req,
  input  logic [tomasulo_pkg::instr_w-1:0] instr,
  input  logic [tomasulo_pkg::reg_w-1:0]   dbg_addr,
  output logic                             instr_ack,
  output logic [tomasulo_pkg::data_w-1:0]  dbg_data,
  output logic                             dbg_busy,
  output logic                             wb_valid,
  output logic [tomasulo_pkg::reg_w-1:0]   wb_dest,
  output logic [tomasulo_pkg::data_w-1:0]  wb_data
);
  import tomasulo_pkg::*;

  // issue logic to register file
  data_t    rd_a_val;
  data_t    rd_b_val;
  logic     rd_a_busy;
  logic     rd_b_busy;
  logic     dest_busy;
  reg_idx_t rd_a_addr;
  reg_idx_t rd_b_addr;
  reg_idx_t dest_addr;
  logic     mark_busy;
  cdb_t     cdb;

  issue_if    add_issue_if ();
  issue_if    mul_issue_if ();
  dispatch_if add_disp_if ();
  dispatch_if mul_disp_if ();
  result_if   add_res_if (.clk(clk));
  result_if   mul_res_if (.clk(clk));

  issue_unit issue_unit_inst (
    .clk(clk), .rst(rst),
    .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
    .rd_a_val(rd_a_val), .rd_b_val(rd_b_val),
    .rd_a_busy(rd_a_busy), .rd_b_busy(rd_b_busy), .dest_busy(dest_busy),
    .rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr), .dest_addr(dest_addr),
    .mark_busy(mark_busy),
    .add_issue(add_issue_if.issuer), .mul_issue(mul_issue_if.issuer)
  );

  register_status_file regfile_inst (
    .clk(clk), .rst(rst),
    .rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr), .dest_addr(dest_addr),
    .dbg_addr(dbg_addr), .mark_busy(mark_busy), .cdb(cdb),
    .rd_a_val(rd_a_val), .rd_b_val(rd_b_val), .dbg_data(dbg_data),
    .rd_a_busy(rd_a_busy), .rd_b_busy(rd_b_busy), .dest_busy(dest_busy),
    .dbg_busy(dbg_busy)
  );

  reservation_station add_rs_inst (
    .clk(clk), .rst(rst), .cdb(cdb),
    .iss(add_issue_if.station), .disp(add_disp_if.station)
  );

  reservation_station mul_rs_inst (
    .clk(clk), .rst(rst), .cdb(cdb),
    .iss(mul_issue_if.station), .disp(mul_disp_if.station)
  );

  functional_unit #(.kind(fu_add), .latency(add_latency)) add_unit_inst (
    .clk(clk), .rst(rst), .disp(add_disp_if.unit), .res(add_res_if.unit)
  );

  functional_unit #(.kind(fu_mul), .latency(mul_latency)) mul_unit_inst (
    .clk(clk), .rst(rst), .disp(mul_disp_if.unit), .res(mul_res_if.unit)
  );

  cdb_arbiter cdb_arbiter_inst (
    .add_res(add_res_if.arbiter), .mul_res(mul_res_if.arbiter), .cdb(cdb)
  );

  // writeback seen from outside is the bus broadcast itself
  assign wb_valid = cdb.valid;
  assign wb_dest  = cdb.dest;
  assign wb_data  = cdb.data;

endmodule

// ==== dv/tb_tomasulo.sv ====
// testbench for the tomasulo integer core
// drives instructions over the req/ack port, keeps an in-order shadow model
// and checks writebacks, debug reads and the handshake with assertions
`timescale 1ns/10ps

module tb_tomasulo;
  import tomasulo_pkg::*;

  logic               clk;
  logic               rst;
  logic               instr_req;
  logic [instr_w-1:0] instr;
  logic [reg_w-1:0]   dbg_addr;
  logic               instr_ack;
  logic [data_w-1:0]  dbg_data;
  logic               dbg_busy;
  logic               wb_valid;
  logic [reg_w-1:0]   wb_dest;
  logic [data_w-1:0]  wb_data;

  // shadow model in program order
  data_t               model_regs [num_regs];
  // value the single pending writer of each register must produce
  data_t               exp_val [num_regs];
  logic [num_regs-1:0] pending;
  int                  alu_issued;
  int                  wb_count;
  // one-edge delayed copies for edge detection
  logic                ack_q;
  logic                req_q;
  logic                rst_q;
  logic                dbg_check_en;

  // one counter per check
  int reset_errs = 0;
  int ack_rise_errs = 0;
  int ack_fall_errs = 0;
  int wb_writer_errs = 0;
  int wb_value_errs = 0;
  int dbg_value_errs = 0;
  int dbg_busy_errs = 0;
  int completion_errs = 0;
  int timeouts = 0;
  int ack_limit = 200;
  int drain_limit = 400;
  integer seed;

  tomasulo_core tomasulo_core_inst (
    .clk(clk), .rst(rst),
    .instr_req(instr_req), .instr(instr), .dbg_addr(dbg_addr),
    .instr_ack(instr_ack), .dbg_data(dbg_data), .dbg_busy(dbg_busy),
    .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // add wraps and multiply keeps the low word
  function automatic data_t alu_result(input opcode_t op, input data_t a, input data_t b);
    data_t res;
    if (op == op_add) begin
      res = a + b;
    end else begin
      res = a * b;
    end
    return res;
  endfunction

  // the instruction is still held one edge after ack rose
  always @(posedge clk) begin : model_update
    opcode_t  m_op;
    reg_idx_t m_dest;
    reg_idx_t m_a;
    reg_idx_t m_b;
    data_t    m_res;
    ack_q <= instr_ack;
    req_q <= instr_req;
    rst_q <= rst;
    if (rst) begin
      for (int r = 0; r < num_regs; r++) begin
        model_regs[r] <= data_t'(r);
        exp_val[r]    <= data_t'(r);
      end
      pending    <= '0;
      alu_issued <= 0;
      wb_count   <= 0;
    end else begin
      if (wb_valid) begin
        wb_count <= wb_count + 1;
        if (wb_dest != '0) begin
          pending[wb_dest] <= 1'b0;
        end
      end
      if (instr_ack && !ack_q) begin
        {m_op, m_dest, m_a, m_b} = instr;
        // nop, ld and st leave the model untouched
        if (m_op == op_add || m_op == op_mul) begin
          m_res = alu_result(m_op, model_regs[m_a], model_regs[m_b]);
          alu_issued <= alu_issued + 1;
          if (m_dest != '0) begin
            model_regs[m_dest] <= m_res;
            exp_val[m_dest]    <= m_res;
            pending[m_dest]    <= 1'b1;
          end
        end
      end
    end
  end

  // first edge out of reset
  reset_idle: assert property (@(posedge clk) rst_q && !rst |-> !instr_ack && !wb_valid)
    else begin
      reset_errs++;
      $display("** Error: instr_ack = %h, wb_valid = %h after reset, expected 0",
               instr_ack, wb_valid);
    end

  ack_rise: assert property (@(posedge clk) disable iff (rst)
    instr_ack && !ack_q |-> req_q)
    else begin
      ack_rise_errs++;
      $display("** Error: instr_ack rose with instr_req = %h, expected 1", req_q);
    end

  ack_fall: assert property (@(posedge clk) disable iff (rst)
    !instr_ack && ack_q |-> !req_q)
    else begin
      ack_fall_errs++;
      $display("** Error: instr_ack fell with instr_req = %h, expected 0", req_q);
    end

  // r0 may have several writers in flight, so its data is not tracked
  wb_writer: assert property (@(posedge clk) disable iff (rst)
    wb_valid && wb_dest != '0 |-> pending[wb_dest])
    else begin
      wb_writer_errs++;
      $display("writeback to r%0d arrived with no instruction pending for it", wb_dest);
    end

  wb_value: assert property (@(posedge clk) disable iff (rst)
    wb_valid && wb_dest != '0 |-> wb_data == exp_val[wb_dest])
    else begin
      wb_value_errs++;
      $display("** Error: wb_data for r%0d = %h, expected %h",
               wb_dest, wb_data, exp_val[wb_dest]);
    end

  dbg_value: assert property (@(posedge clk) disable iff (rst)
    dbg_check_en |-> dbg_data == model_regs[dbg_addr])
    else begin
      dbg_value_errs++;
      $display("** Error: dbg_data at r%0d = %h, expected %h",
               dbg_addr, dbg_data, model_regs[dbg_addr]);
    end

  dbg_idle: assert property (@(posedge clk) disable iff (rst)
    dbg_check_en |-> !dbg_busy)
    else begin
      dbg_busy_errs++;
      $display("** Error: dbg_busy at r%0d = %h, expected 0", dbg_addr, dbg_busy);
    end

  // one four-phase transfer, called and returning on a falling edge
  task automatic send_instr(input opcode_t op, input reg_idx_t dest,
                            input reg_idx_t a, input reg_idx_t b);
    int waited;
    if (timeouts > 0) return;
    waited = 0;
    instr = {op, dest, a, b};
    instr_req = 1'b1;
    @(negedge clk);
    while (!instr_ack && waited < ack_limit) begin
      waited++;
      @(negedge clk);
    end
    instr_req = 1'b0;
    if (!instr_ack) begin
      timeouts++;
      $display("timeout: instruction %h was never acknowledged", instr);
    end else begin
      waited = 0;
      while (instr_ack && waited < ack_limit) begin
        waited++;
        @(negedge clk);
      end
      if (instr_ack) begin
        timeouts++;
        $display("timeout: instr_ack stayed high after the request was dropped");
      end
    end
  endtask

  // every register through the debug port
  // nothing is in flight here, so every busy bit must already be clear
  task automatic sweep_debug();
    for (int r = 0; r < num_regs; r++) begin
      dbg_addr = reg_idx_t'(r);
      @(negedge clk);
      dbg_check_en = 1'b1;
      @(negedge clk);
      dbg_check_en = 1'b0;
    end
  endtask

  // all issued results written back, then compare the whole file
  task automatic wait_drained();
    int waited;
    if (timeouts > 0) return;
    waited = 0;
    while (wb_count != alu_issued && waited < drain_limit) begin
      waited++;
      @(negedge clk);
    end
    if (wb_count != alu_issued) begin
      timeouts++;
      $display("timeout: %0d of %0d results written back", wb_count, alu_issued);
    end else begin
      sweep_debug();
    end
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    opcode_t     op;
    int          total;
    clk = 1'b0;
    rst = 1'b1;
    instr_req = 1'b0;
    instr = '0;
    dbg_addr = '0;
    dbg_check_en = 1'b0;
    seed = 32'ha03c200a;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // rN reads N after reset
    sweep_debug();

    // single add then single multiply
    send_instr(op_add, 3'd1, 3'd2, 3'd3);
    wait_drained();
    send_instr(op_mul, 3'd4, 3'd5, 3'd6);
    wait_drained();

    // dependent chain that writes r3 twice and ends in r0
    send_instr(op_add, 3'd3, 3'd1, 3'd2);
    send_instr(op_mul, 3'd5, 3'd3, 3'd3);
    send_instr(op_add, 3'd3, 3'd5, 3'd1);
    send_instr(op_mul, 3'd6, 3'd3, 3'd5);
    send_instr(op_add, 3'd0, 3'd6, 3'd6);
    wait_drained();

    // random mix long enough to fill both stations
    for (int i = 0; i < 48; i++) begin
      rnd = $random(seed);
      if (rnd[2:0] < 3'd3) begin
        op = op_add;
      end else if (rnd[2:0] < 3'd6) begin
        op = op_mul;
      end else if (rnd[2:0] == 3'd6) begin
        op = op_nop;
      end else if (rnd[12]) begin
        op = op_ld;
      end else begin
        op = op_st;
      end
      send_instr(op, rnd[5:3], rnd[8:6], rnd[11:9]);
    end
    wait_drained();

    if (timeouts == 0) begin
      all_retired: assert (wb_count == alu_issued && pending == '0)
        else begin
          completion_errs++;
          $display("results missing: %0d issued, %0d written back, pending mask %h",
                   alu_issued, wb_count, pending);
        end
    end

    total = reset_errs + ack_rise_errs + ack_fall_errs + wb_writer_errs + wb_value_errs
          + dbg_value_errs + dbg_busy_errs + completion_errs + timeouts;
    $write("error counts: reset %0d, ack rise %0d, ack fall %0d, ",
           reset_errs, ack_rise_errs, ack_fall_errs);
    $write("wb writer %0d, wb value %0d, dbg value %0d, ",
           wb_writer_errs, wb_value_errs, dbg_value_errs);
    $display("dbg busy %0d, completion %0d, timeouts %0d",
             dbg_busy_errs, completion_errs, timeouts);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/tomasulo_pkg.sv
src/tomasulo_ifs.sv
src/issue_unit.sv
src/register_status_file.sv
src/reservation_station.sv
src/functional_unit.sv
src/cdb_arbiter.sv
src/tomasulo_core.sv
dv/tb_tomasulo.sv

// ==== Makefile ====
# verilator build and run of the tomasulo core testbench
TOP := tb_tomasulo

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
